// File: compile.f
+incdir+hw
hw/mmm_pkg.sv
hw/operand_dispatch.sv
hw/row_multiplier.sv
hw/column_accumulator.sv
hw/bigint_multiplier_top.sv
testbench/tb_bigint_multiplier.sv

// File: hw/bigint_multiplier_top.sv
/*
  Pipelined multi-precision multiplier
  Dispatcher, one row lane per limb of a, and the column accumulator.
  Three stages, one request per cycle when not stalled.
*/

`timescale 1ns/100ps

`include "mmm_consts.svh"

module bigint_multiplier_top (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_val,
  input  mmm_pkg::mul_req_t i_req,
  output logic              o_ready,
  output logic              o_val,
  output mmm_pkg::mul_rsp_t o_rsp,
  input  logic              i_ready
);

  logic                             advance;
  logic                             disp_val;
  mmm_pkg::mul_req_t                disp_req;
  logic [`MMM_NUM_LIMBS-1:0]        lane_val;
  mmm_pkg::row_prod_t               lane_row  [`MMM_NUM_LIMBS];
  // Only lane 0 carries the side copy forward
  mmm_pkg::mul_req_t                lane_side [`MMM_NUM_LIMBS];

  operand_dispatch dispatch_i (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_val     (i_val),
    .i_req     (i_req),
    .i_advance (advance),
    .o_ready   (o_ready),
    .o_val     (disp_val),
    .o_req     (disp_req)
  );

  for (genvar i = 0; i < `MMM_NUM_LIMBS; i++) begin : g_lane
    row_multiplier lane_i (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_advance (advance),
      .i_val     (disp_val),
      .i_a_limb  (disp_req.a[i*`MMM_LIMB_W +: `MMM_LIMB_W]),
      .i_b       (disp_req.b),
      .i_side    (disp_req),
      .o_val     (lane_val[i]),
      .o_row     (lane_row[i]),
      .o_side    (lane_side[i])
    );
  end

  column_accumulator accum_i (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_val     (lane_val),
    .i_rows    (lane_row),
    .i_side    (lane_side[0]),
    .i_ready   (i_ready),
    .o_advance (advance),
    .o_val     (o_val),
    .o_rsp     (o_rsp)
  );

endmodule

// File: hw/column_accumulator.sv
/*
  Column accumulator
  Shifts each lane row into its column position, sums the rows and the
  add term in an adder tree, selects the result limbs by opcode and holds
  the response register under back-pressure. Also generates the advance
  enable for the whole pipeline.
*/

`timescale 1ns/100ps

`include "mmm_consts.svh"

module column_accumulator (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic [`MMM_NUM_LIMBS-1:0]  i_val,
  input  mmm_pkg::row_prod_t         i_rows [`MMM_NUM_LIMBS],
  input  mmm_pkg::mul_req_t          i_side,
  input  logic                       i_ready,
  output logic                       o_advance,
  output logic                       o_val,
  output mmm_pkg::mul_rsp_t          o_rsp
);

  localparam int N       = `MMM_NUM_LIMBS;
  localparam int W       = `MMM_LIMB_W;
  localparam int HALF_W  = N*W;
  localparam int FULL_W  = 2*N*W;
  // Rows plus add term, padded up to a power of two
  localparam int TREE_SZ = 1 << $clog2(N+1);

  logic [FULL_W-1:0] tree [TREE_SZ];
  logic [FULL_W-1:0] full_sum;
  logic [FULL_W-1:0] sel_dat;
  logic              row_val;

  // All lanes move in lockstep, lane 0 stands for the stage
  assign row_val = i_val[0];

  // Output slot free or being emptied this cycle
  assign o_advance = !o_val || i_ready;

  // Adder tree over the shifted rows and the add term at bit 0
  always_comb begin
    for (int k = 0; k < TREE_SZ; k++) begin
      tree[k] = '0;
    end
    for (int i = 0; i < N; i++) begin
      tree[i] = FULL_W'(i_rows[i].dat) << (i*W);
    end
    tree[N] = FULL_W'(i_side.add);
    // Pairwise reduction, level by level
    for (int step = 1; step < TREE_SZ; step = step * 2) begin
      for (int k = 0; k + step < TREE_SZ; k = k + 2*step) begin
        tree[k] = tree[k] + tree[k+step];
      end
    end
    full_sum = tree[0];
  end

  // Limb select by opcode
  always_comb begin
    case (i_side.op)
      mmm_pkg::OP_LO: begin
        sel_dat = {{HALF_W{1'b0}}, full_sum[HALF_W-1:0]};
      end
      mmm_pkg::OP_HI: begin
        sel_dat = {{HALF_W{1'b0}}, full_sum[FULL_W-1:HALF_W]};
      end
      default: begin
        sel_dat = full_sum;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_val <= 1'b0;
    end else if (o_advance) begin
      o_val <= row_val;
    end
  end

  // Response payload
  always_ff @(posedge i_clk) begin
    if (o_advance && row_val) begin
      o_rsp.op  <= i_side.op;
      o_rsp.dat <= sel_dat;
    end
  end

  // Stalled response must be held unchanged until it is taken
  a_rsp_stable : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (o_val && !i_ready) |=> (o_val && $stable(o_rsp))
  ) else $error("column_accumulator: response changed while stalled");

  // Lanes share one advance, so their valid bits never diverge
  a_lanes_agree : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_val == '0) || (i_val == '1)
  ) else $error("column_accumulator: lane valid bits disagree %b", i_val);

endmodule

// File: hw/mmm_consts.svh
/*
  Multi-precision multiplier constants
  Operand geometry and pipeline depth shared by the RTL and the testbench
*/

`ifndef MMM_CONSTS_SVH
`define MMM_CONSTS_SVH

// Limbs per operand
`define MMM_NUM_LIMBS 4

// Bits per limb
`define MMM_LIMB_W 16

// Register stages from acceptance to response without stalls
`define MMM_PIPE_DEPTH 3

`endif

// File: hw/mmm_pkg.sv
/*
  Multi-precision multiplier types
  Opcode enum and the packed structs carried between the pipeline stages
*/

`include "mmm_consts.svh"

package mmm_pkg;

  // Operation select
  typedef enum logic [1:0] {
    OP_LO  = 2'd0,
    OP_HI  = 2'd1,
    OP_SQR = 2'd2
  } mul_op_e;

  // Request from the host, each operand packed limb 0 first at bit 0
  typedef struct packed {
    mul_op_e                                  op;
    logic [`MMM_NUM_LIMBS*`MMM_LIMB_W-1:0]   a;
    logic [`MMM_NUM_LIMBS*`MMM_LIMB_W-1:0]   b;
    logic [`MMM_NUM_LIMBS*`MMM_LIMB_W-1:0]   add;
  } mul_req_t;

  // One lane result, a_i times all of b, not yet shifted into place
  typedef struct packed {
    logic [(`MMM_NUM_LIMBS+1)*`MMM_LIMB_W-1:0] dat;
  } row_prod_t;

  // Response, selected limbs sit in the lower half for OP_LO and OP_HI
  typedef struct packed {
    mul_op_e                                  op;
    logic [2*`MMM_NUM_LIMBS*`MMM_LIMB_W-1:0] dat;
  } mul_rsp_t;

endpackage

// File: hw/operand_dispatch.sv
/*
  Operand dispatcher
  Accepts multiply requests and registers the operands broadcast to the
  row lanes. Squares have b replaced by a here so that the lanes never
  need to decode the opcode.
*/

`timescale 1ns/100ps

module operand_dispatch (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_val,
  input  mmm_pkg::mul_req_t i_req,
  input  logic              i_advance,
  output logic              o_ready,
  output logic              o_val,
  output mmm_pkg::mul_req_t o_req
);

  mmm_pkg::mul_req_t req_d;
  logic              accept;

  // Pipeline moves as a whole, so readiness is just the advance enable
  assign o_ready = i_advance;
  assign accept  = i_val && i_advance;

  // Square mode reuses a as the second operand
  always_comb begin
    req_d = i_req;
    if (i_req.op == mmm_pkg::OP_SQR) begin
      req_d.b = i_req.a;
    end
  end

  // Stage valid
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_val <= 1'b0;
    end else if (i_advance) begin
      o_val <= i_val;
    end
  end

  // Operand register, only loaded on a real transfer
  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_req <= req_d;
    end
  end

  // Host must only send one of the defined operations
  a_op_legal : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    accept |-> (i_req.op inside {mmm_pkg::OP_LO, mmm_pkg::OP_HI, mmm_pkg::OP_SQR})
  ) else $error("operand_dispatch: illegal opcode %0d accepted", i_req.op);

  // A held request may not change until it is taken
  a_req_hold : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_val && !i_advance) |=> (i_val && $stable(i_req))
  ) else $error("operand_dispatch: request changed while stalled");

endmodule

// File: hw/row_multiplier.sv
/*
  Row multiplier lane
  Multiplies one limb of a by every limb of b and merges the limb
  products into a single row value of NUM_LIMBS+1 limbs. The request
  travels beside the row as a side copy.
*/

`timescale 1ns/100ps

`include "mmm_consts.svh"

module row_multiplier (
  input  logic                                    i_clk,
  input  logic                                    i_rst_n,
  input  logic                                    i_advance,
  input  logic                                    i_val,
  input  logic [`MMM_LIMB_W-1:0]                  i_a_limb,
  input  logic [`MMM_NUM_LIMBS*`MMM_LIMB_W-1:0]   i_b,
  input  mmm_pkg::mul_req_t                       i_side,
  output logic                                    o_val,
  output mmm_pkg::row_prod_t                      o_row,
  output mmm_pkg::mul_req_t                       o_side
);

  localparam int N = `MMM_NUM_LIMBS;
  localparam int W = `MMM_LIMB_W;

  logic [2*W-1:0]     prod [N];
  logic [(N+1)*W-1:0] row_d;
  logic [W:0]         limb_sum;
  logic               carry;

  // Limb products
  always_comb begin
    for (int j = 0; j < N; j++) begin
      prod[j] = i_a_limb * i_b[j*W +: W];
    end
  end

  // High half of product j-1 lands on the low half of product j
  always_comb begin
    carry       = 1'b0;
    limb_sum    = '0;
    row_d       = '0;
    row_d[W-1:0] = prod[0][W-1:0];
    for (int j = 1; j < N; j++) begin
      limb_sum = {1'b0, prod[j-1][2*W-1:W]} + {1'b0, prod[j][W-1:0]} +
                 {{W{1'b0}}, carry};
      row_d[j*W +: W] = limb_sum[W-1:0];
      carry           = limb_sum[W];
    end
    // Top limb cannot overflow since a_i * b < 2^((N+1)*W)
    row_d[N*W +: W] = prod[N-1][2*W-1:W] + {{(W-1){1'b0}}, carry};
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_val <= 1'b0;
    end else if (i_advance) begin
      o_val <= i_val;
    end
  end

  // Row and side payload
  always_ff @(posedge i_clk) begin
    if (i_advance && i_val) begin
      o_row.dat <= row_d;
      o_side    <= i_side;
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -sv \
  -f compile.f \
  --top-module tb_bigint_multiplier \
  -Mdir "$BUILD_DIR" \
  -o sim_tb

"./$BUILD_DIR/sim_tb" | tee "$LOG"

if grep -q "^TEST PASSED$" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG"
  exit 1
fi

// File: testbench/tb_bigint_multiplier.sv
/*
  Testbench for the pipelined multi-precision multiplier
  Drives LFSR-based traffic through the request port, predicts each
  response with a 128-bit reference model and checks order, latency,
  back-pressure hold and request/response counts.
*/

`timescale 1ns/100ps

`include "mmm_consts.svh"

module tb_bigint_multiplier;

  localparam int N        = `MMM_NUM_LIMBS;
  localparam int W        = `MMM_LIMB_W;
  localparam int OPW      = N*W;
  localparam int FULL_W   = 2*OPW;
  localparam int RSP_W    = $bits(mmm_pkg::mul_rsp_t);
  localparam int N_DIRECT = 12;
  localparam int N_LOHI   = 200;
  localparam int N_SQR    = 100;
  localparam int N_MIXED  = 300;
  localparam int WATCHDOG_CYCLES = (N_DIRECT + N_LOHI + N_SQR + N_MIXED) * 8 + 200;

  logic              i_clk;
  logic              i_rst_n;
  logic              i_val;
  mmm_pkg::mul_req_t i_req;
  logic              o_ready;
  logic              o_val;
  mmm_pkg::mul_rsp_t o_rsp;
  logic              i_ready;

  logic [31:0]       lfsr_state = 32'h6dca_8223;
  mmm_pkg::mul_req_t stim_q [$];
  logic [RSP_W-1:0]  exp_q [$];
  int                acc_q [$];
  string             cur_test = "reset";
  logic              check_timing = 1'b0;
  logic              req_fire = 1'b0;
  logic              rsp_fire = 1'b0;
  logic              held_val = 1'b0;
  logic [RSP_W-1:0]  held_rsp;
  int                cycle = 0;
  int                errors = 0;
  int                req_count = 0;
  int                rsp_count = 0;
  int                total_req = 0;
  int                total_rsp = 0;
  int                n_tests = 0;

  bigint_multiplier_top dut_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_val   (i_val),
    .i_req   (i_req),
    .o_ready (o_ready),
    .o_val   (o_val),
    .o_rsp   (o_rsp),
    .i_ready (i_ready)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] draw_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [OPW-1:0] rand_operand();
    logic [OPW-1:0] v;
    for (int k = 0; k < N; k++) begin
      v[k*W +: W] = W'(draw_bits(W));
    end
    return v;
  endfunction

  function automatic mmm_pkg::mul_req_t make_req(input mmm_pkg::mul_op_e op,
      input logic [OPW-1:0] a, input logic [OPW-1:0] b, input logic [OPW-1:0] add);
    mmm_pkg::mul_req_t r;
    r.op  = op;
    r.a   = a;
    r.b   = b;
    r.add = add;
    return r;
  endfunction

  // Full product plus add term, then limb selection by opcode
  function automatic logic [RSP_W-1:0] ref_response(input mmm_pkg::mul_req_t req);
    logic [FULL_W-1:0] full;
    logic [FULL_W-1:0] dat;
    logic [OPW-1:0]    b_eff;
    b_eff = (req.op == mmm_pkg::OP_SQR) ? req.a : req.b;
    full  = FULL_W'(req.a) * FULL_W'(b_eff) + FULL_W'(req.add);
    case (req.op)
      mmm_pkg::OP_LO: dat = {{OPW{1'b0}}, full[OPW-1:0]};
      mmm_pkg::OP_HI: dat = {{OPW{1'b0}}, full[FULL_W-1:OPW]};
      default:        dat = full;
    endcase
    return {req.op, dat};
  endfunction

  task automatic check_value(input string name, input logic [RSP_W-1:0] exp_v,
      input logic [RSP_W-1:0] act_v);
    if (exp_v !== act_v) begin
      $display("** Error %s: expected %h, actual %h", name, exp_v, act_v);
      errors++;
    end
  endtask

  // Handshakes are sampled mid-cycle, where every signal has settled
  always @(negedge i_clk) begin
    logic [RSP_W-1:0] exp_rsp;
    int               acc_cyc;
    cycle    = cycle + 1;
    req_fire = i_rst_n && i_val && o_ready;
    rsp_fire = i_rst_n && o_val && i_ready;
    if (!i_rst_n) begin
      held_val = 1'b0;
    end else begin
      if (held_val) begin
        if (!o_val) begin
          $display("Failure in %s: response withdrawn while stalled", cur_test);
          errors++;
        end else begin
          check_value({cur_test, " stall hold"}, held_rsp, o_rsp);
        end
      end
      held_val = o_val && !i_ready;
      held_rsp = o_rsp;
      if (check_timing && !o_ready) begin
        $display("Failure in %s: o_ready low with i_ready held high", cur_test);
        errors++;
      end
      if (req_fire) begin
        exp_q.push_back(ref_response(i_req));
        acc_q.push_back(cycle);
        req_count++;
        total_req++;
      end
      if (rsp_fire) begin
        if (exp_q.size() == 0) begin
          $display("Failure in %s: response with no request outstanding", cur_test);
          errors++;
        end else begin
          exp_rsp = exp_q.pop_front();
          acc_cyc = acc_q.pop_front();
          check_value(cur_test, exp_rsp, o_rsp);
          if (check_timing) begin
            check_value({cur_test, " latency"}, RSP_W'(`MMM_PIPE_DEPTH),
                        RSP_W'(cycle - acc_cyc));
          end
        end
        rsp_count++;
        total_rsp++;
      end
    end
  end

  // Request stays on the bus until taken, gaps only between requests
  task automatic send_all(input bit gaps, input bit stalls);
    bit done;
    done = 1'b0;
    while (!done) begin
      @(posedge i_clk);
      i_ready <= stalls ? (draw_bits(2) != 64'd0) : 1'b1;
      if (!i_val || req_fire) begin
        if (stim_q.size() == 0) begin
          i_val <= 1'b0;
          done = 1'b1;
        end else if (gaps && draw_bits(2) == 64'd0) begin
          i_val <= 1'b0;
        end else begin
          i_req <= stim_q.pop_front();
          i_val <= 1'b1;
        end
      end
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge i_clk);
      i_ready <= 1'b1;
    end
    @(posedge i_clk);
  endtask

  task automatic run_test(input string name, input bit gaps, input bit stalls,
      input bit timing);
    int err0;
    err0         = errors;
    cur_test     = name;
    check_timing = timing;
    req_count    = 0;
    rsp_count    = 0;
    send_all(gaps, stalls);
    drain();
    check_timing = 1'b0;
    check_value({name, " count"}, RSP_W'(req_count), RSP_W'(rsp_count));
    $display("test %-18s requests %0d  responses %0d  errors %0d",
             name, req_count, rsp_count, errors - err0);
    n_tests++;
  endtask

  // Zeros, longest carry chain, lone low limb and lone high limb
  task automatic push_corners(input mmm_pkg::mul_op_e op);
    logic [OPW-1:0] ones;
    logic [OPW-1:0] lo_limb;
    logic [OPW-1:0] hi_limb;
    ones    = '1;
    lo_limb = OPW'({W{1'b1}});
    hi_limb = lo_limb << (OPW - W);
    stim_q.push_back(make_req(op, '0, '0, '0));
    stim_q.push_back(make_req(op, ones, ones, ones));
    stim_q.push_back(make_req(op, lo_limb, lo_limb, lo_limb));
    stim_q.push_back(make_req(op, hi_limb, hi_limb, hi_limb));
  endtask

  initial begin
    mmm_pkg::mul_op_e op;
    logic [OPW-1:0]   a;
    logic [OPW-1:0]   b;
    i_rst_n = 1'b0;
    i_val   = 1'b0;
    i_req   = '0;
    i_ready = 1'b1;
    repeat (16) @(posedge i_clk);
    i_rst_n <= 1'b1;

    @(negedge i_clk);
    if (o_val !== 1'b0 || o_ready !== 1'b1) begin
      $display("Failure in reset: o_val low and o_ready high expected after reset");
      errors++;
    end
    $display("test %-18s o_val %b  o_ready %b", "reset", o_val, o_ready);
    n_tests++;

    push_corners(mmm_pkg::OP_LO);
    push_corners(mmm_pkg::OP_HI);
    push_corners(mmm_pkg::OP_SQR);
    run_test("directed", 1'b0, 1'b0, 1'b1);

    for (int k = 0; k < N_LOHI; k++) begin
      op = draw_bits(1) != 64'd0 ? mmm_pkg::OP_HI : mmm_pkg::OP_LO;
      stim_q.push_back(make_req(op, rand_operand(), rand_operand(), rand_operand()));
    end
    run_test("random_lo_hi", 1'b0, 1'b0, 1'b1);

    // b is filled with a value other than a and must have no effect
    for (int k = 0; k < N_SQR; k++) begin
      a = rand_operand();
      b = rand_operand();
      if (b == a) begin
        b = ~a;
      end
      stim_q.push_back(make_req(mmm_pkg::OP_SQR, a, b, rand_operand()));
    end
    run_test("square_b_ignored", 1'b0, 1'b0, 1'b1);

    for (int k = 0; k < N_MIXED; k++) begin
      case (draw_bits(2))
        64'd0:   op = mmm_pkg::OP_LO;
        64'd1:   op = mmm_pkg::OP_HI;
        default: op = mmm_pkg::OP_SQR;
      endcase
      stim_q.push_back(make_req(op, rand_operand(), rand_operand(), rand_operand()));
    end
    run_test("backpressure_mixed", 1'b1, 1'b1, 1'b0);

    $display("summary: %0d tests, %0d requests, %0d responses, %0d errors",
             n_tests, total_req, total_rsp, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule
